// File: common/harness_pkg.sv
// Harness shared definitions

package harness_pkg;

  // ------------------
  // bus widths
  // ------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned AddrWidth = 32;

  // region nibble plus two byte offset bits
  localparam int unsigned WordIdxWidth = AddrWidth - 4 - 2;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ------------------
  // address map
  // ------------------
  // upper nibble of the byte address, anything not listed is an error
  typedef enum logic [3:0] {
    RegionRom  = 4'h0,
    RegionSram = 4'h8
  } region_e;

  typedef struct packed {
    region_e                 region;
    logic [WordIdxWidth-1:0] word_idx;
    logic [1:0]              byte_off;
  } bus_addr_fields_t;

  // same word seen as a flat byte address or split into its fields
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    bus_addr_fields_t     fields;
  } bus_addr_u;

  // ------------------
  // fixed values
  // ------------------
  // returned on any unmapped or illegal access
  localparam data_t ErrData = 32'hBADCAB1E;

  localparam int unsigned RomWords = 8;

endpackage

// File: mem/boot_rom.sv
// Boot ROM

`timescale 1ns/1ps

module boot_rom (
  input  logic                                     clk_i,
  input  logic                                     req_i,
  input  logic [$clog2(harness_pkg::RomWords)-1:0] idx_i,
  output harness_pkg::data_t                       rdata_o
);

  import harness_pkg::*;

  data_t word;

  // hart id into a0, then jump to sram base
  always_comb begin
    case (idx_i)
      3'd0:    word = 32'hF1402573; // csrr a0, mhartid
      3'd1:    word = 32'h800002B7; // lui t0, 0x80000
      3'd2:    word = 32'h00000593; // li a1, 0
      3'd3:    word = 32'h00028067; // jr t0
      3'd4:    word = 32'h00000013;
      3'd5:    word = 32'h00000013;
      3'd6:    word = 32'h10500073; // wfi
      default: word = 32'hFFDFF06F; // back to wfi
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= word;
    end
  end

endmodule

// File: mem/sram_bank.sv
// Byte-enable SRAM bank

`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned SramWords = 256
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(SramWords)-1:0] idx_i,
  input  harness_pkg::strb_t           be_i,
  input  harness_pkg::data_t           wdata_i,
  output harness_pkg::data_t           rdata_o
);

  import harness_pkg::*;

  data_t mem_q [SramWords];

  // simulation starts from a cleared array
  initial begin
    for (int i = 0; i < SramWords; i++) begin
      mem_q[i] = '0;
    end
  end

  // ------------------
  // access port
  // ------------------
  // writes only touch enabled lanes, reads land one cycle later
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

// File: rtl/bus_access_fsm.sv
// Bus access state machine

`timescale 1ns/1ps

module bus_access_fsm #(
  parameter int unsigned SramWords = 256
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_valid_i,
  input  logic                                     req_we_i,
  input  harness_pkg::bus_addr_u                   req_addr_i,
  input  harness_pkg::strb_t                       req_be_i,
  input  harness_pkg::data_t                       req_wdata_i,
  output logic                                     req_ready_o,
  input  logic                                     rsp_ready_i,
  output logic                                     rsp_valid_o,
  output harness_pkg::data_t                       rsp_rdata_o,
  output logic                                     rsp_err_o,
  output logic                                     sram_req_o,
  output logic                                     sram_we_o,
  output logic [$clog2(SramWords)-1:0]             sram_idx_o,
  output harness_pkg::strb_t                       sram_be_o,
  output harness_pkg::data_t                       sram_wdata_o,
  input  harness_pkg::data_t                       sram_rdata_i,
  output logic                                     rom_req_o,
  output logic [$clog2(harness_pkg::RomWords)-1:0] rom_idx_o,
  input  harness_pkg::data_t                       rom_rdata_i
);

  import harness_pkg::*;

  localparam int unsigned SramIdxW = $clog2(SramWords);
  localparam int unsigned RomIdxW  = $clog2(RomWords);

  localparam logic [1:0] StIdle   = 2'd0;
  localparam logic [1:0] StAccess = 2'd1;
  localparam logic [1:0] StResp   = 2'd2;

  // response source, picked in ACCESS and held through RESP
  localparam logic [1:0] SelZero = 2'd0;
  localparam logic [1:0] SelRom  = 2'd1;
  localparam logic [1:0] SelSram = 2'd2;
  localparam logic [1:0] SelErr  = 2'd3;

  logic [1:0] state_q, state_d;
  logic [1:0] sel_q, sel_d;

  logic      we_q;
  bus_addr_u addr_q;
  strb_t     be_q;
  data_t     wdata_q;

  logic hit_rom;
  logic hit_sram;

  // ------------------
  // region decode
  // ------------------
  // rom is read only
  assign hit_rom  = (addr_q.fields.region == RegionRom) && !we_q &&
                    (addr_q.fields.word_idx < RomWords);
  assign hit_sram = (addr_q.fields.region == RegionSram) &&
                    (addr_q.fields.word_idx < SramWords);

  always_comb begin
    if (hit_sram) begin
      sel_d = we_q ? SelZero : SelSram;
    end else if (hit_rom) begin
      sel_d = SelRom;
    end else begin
      sel_d = SelErr;
    end
  end

  // ------------------
  // state machine
  // ------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:   if (req_valid_i) state_d = StAccess;
      StAccess: state_d = StResp;
      StResp:   if (rsp_ready_i) state_d = StIdle;
      default:  state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      sel_q   <= SelZero;
    end else begin
      state_q <= state_d;
      if (state_q == StAccess) begin
        sel_q <= sel_d;
      end
    end
  end

  // accepted request, held until the next acceptance
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q        <= req_we_i;
      addr_q.flat <= req_addr_i.flat;
      be_q        <= req_be_i;
      wdata_q     <= req_wdata_i;
    end
  end

  // ------------------
  // outputs
  // ------------------
  assign req_ready_o = (state_q == StIdle);
  assign rsp_valid_o = (state_q == StResp);

  // one cycle strobes, error accesses touch neither memory
  assign sram_req_o   = (state_q == StAccess) && hit_sram;
  assign sram_we_o    = we_q;
  assign sram_idx_o   = addr_q.fields.word_idx[SramIdxW-1:0];
  assign sram_be_o    = be_q;
  assign sram_wdata_o = wdata_q;

  assign rom_req_o = (state_q == StAccess) && hit_rom;
  assign rom_idx_o = addr_q.fields.word_idx[RomIdxW-1:0];

  // memory read ports keep their word until the next request
  always_comb begin
    case (sel_q)
      SelRom:  rsp_rdata_o = rom_rdata_i;
      SelSram: rsp_rdata_o = sram_rdata_i;
      SelErr:  rsp_rdata_o = ErrData;
      default: rsp_rdata_o = '0;
    endcase
  end

  assign rsp_err_o = (sel_q == SelErr);

endmodule

// File: rtl/dbg_hold_timer.sv
// Debug request hold-off

`timescale 1ns/1ps

module dbg_hold_timer #(
  parameter int unsigned HoldCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic dbg_enable_i,
  output logic dbg_req_o
);

  localparam int unsigned CntW = $clog2(HoldCycles + 1);

  logic [CntW-1:0] cnt_q;
  logic            hold;

  assign hold = (cnt_q != '0);

  // ------------------
  // countdown
  // ------------------
  // stops at zero and stays there until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(HoldCycles);
    end else if (hold) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // boot code runs undisturbed while the window is open
  assign dbg_req_o = !hold && dbg_enable_i && dbg_req_i;

endmodule

// File: rtl/harness_top.sv
// Harness top level

`timescale 1ns/1ps

module harness_top #(
  parameter int unsigned SramWords  = 256,
  parameter int unsigned HoldCycles = 500
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  logic                  req_we_i,
  input  harness_pkg::bus_addr_u req_addr_i,
  input  harness_pkg::strb_t    req_be_i,
  input  harness_pkg::data_t    req_wdata_i,
  output logic                  req_ready_o,
  input  logic                  rsp_ready_i,
  output logic                  rsp_valid_o,
  output harness_pkg::data_t    rsp_rdata_o,
  output logic                  rsp_err_o,
  input  logic                  dbg_req_i,
  input  logic                  dbg_enable_i,
  output logic                  dbg_req_o
);

  import harness_pkg::*;

  localparam int unsigned SramIdxW = $clog2(SramWords);
  localparam int unsigned RomIdxW  = $clog2(RomWords);

  // sram port
  logic                sram_req;
  logic                sram_we;
  logic [SramIdxW-1:0] sram_idx;
  strb_t               sram_be;
  data_t               sram_wdata;
  data_t               sram_rdata;

  // rom port
  logic               rom_req;
  logic [RomIdxW-1:0] rom_idx;
  data_t              rom_rdata;

  // ------------------
  // bus access
  // ------------------
  bus_access_fsm #(
    .SramWords ( SramWords )
  ) u_fsm (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .req_valid_i  ( req_valid_i ),
    .req_we_i     ( req_we_i    ),
    .req_addr_i   ( req_addr_i  ),
    .req_be_i     ( req_be_i    ),
    .req_wdata_i  ( req_wdata_i ),
    .req_ready_o  ( req_ready_o ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .sram_req_o   ( sram_req    ),
    .sram_we_o    ( sram_we     ),
    .sram_idx_o   ( sram_idx    ),
    .sram_be_o    ( sram_be     ),
    .sram_wdata_o ( sram_wdata  ),
    .sram_rdata_i ( sram_rdata  ),
    .rom_req_o    ( rom_req     ),
    .rom_idx_o    ( rom_idx     ),
    .rom_rdata_i  ( rom_rdata   )
  );

  // ------------------
  // memories
  // ------------------
  sram_bank #(
    .SramWords ( SramWords )
  ) u_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  boot_rom u_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  // ------------------
  // debug gate
  // ------------------
  dbg_hold_timer #(
    .HoldCycles ( HoldCycles )
  ) u_hold (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .dbg_req_o    ( dbg_req_o    )
  );

endmodule

// File: soc_harness.f
common/harness_pkg.sv
mem/sram_bank.sv
mem/boot_rom.sv
rtl/dbg_hold_timer.sv
rtl/bus_access_fsm.sv
rtl/harness_top.sv
tests/harness_checker.sv
tests/tb_harness.sv

// File: tests/harness_checker.sv
// Harness response checker

`timescale 1ns/1ps

module harness_checker #(
  parameter int unsigned HoldCycles = 16
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_valid_i,
  input logic               req_ready_i,
  input logic               rsp_valid_i,
  input logic               rsp_ready_i,
  input harness_pkg::data_t rsp_rdata_i,
  input logic               rsp_err_i,
  input logic               dbg_req_i,
  input logic               dbg_enable_i,
  input logic               dbg_gated_i
);

  import harness_pkg::*;

  data_t exp_data_q [$];
  logic  exp_err_q  [$];

  int    err_count      = 0;
  int    rsp_count      = 0;
  int    edge_cnt       = 0;
  int    accept_edge    = 0;
  int    test_errs      = 0;
  int    dbg_errs       = 0;
  int    dbg_tests_done = 0;
  bit    prev_valid     = 1'b0;
  bit    hold_pend      = 1'b0;
  bit    dbg_dis_seen   = 1'b0;
  data_t hold_data;
  logic  hold_err;

  task automatic push_expect(input data_t data, input logic err);
    exp_data_q.push_back(data);
    exp_err_q.push_back(err);
  endtask

  task automatic print_summary();
    if (exp_data_q.size() != 0) begin
      $display("error: %0d expected responses never arrived", exp_data_q.size());
      err_count++;
    end
    err_count += test_errs + dbg_errs;
    test_errs = 0;
    dbg_errs  = 0;
    $display("checked %0d accesses and %0d debug tests, %0d errors",
             rsp_count, dbg_tests_done, err_count);
  endtask

  always @(posedge clk_i) begin
    data_t exp_data;
    logic  exp_err;
    logic  dbg_exp;
    if (rst_ni) begin
      edge_cnt++;

      // ------------------
      // response channel
      // ------------------
      if (req_valid_i && req_ready_i) begin
        accept_edge = edge_cnt;
      end
      if (rsp_valid_i && !prev_valid && (edge_cnt - accept_edge != 2)) begin
        $display("Mismatch at %0t: response came %0d edges after acceptance, expected 2",
                 $time, edge_cnt - accept_edge);
        test_errs++;
      end
      if (rsp_valid_i && req_ready_i) begin
        $display("error at %0t: request channel ready while a response is pending", $time);
        test_errs++;
      end
      // stalled response must not move
      if (hold_pend && (!rsp_valid_i || rsp_rdata_i !== hold_data ||
                        rsp_err_i !== hold_err)) begin
        $display("Mismatch at %0t: stalled response changed to valid %b data %h err %b",
                 $time, rsp_valid_i, rsp_rdata_i, rsp_err_i);
        test_errs++;
      end
      hold_pend = rsp_valid_i && !rsp_ready_i;
      hold_data = rsp_rdata_i;
      hold_err  = rsp_err_i;

      if (rsp_valid_i && rsp_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("error at %0t: response arrived with no access pending", $time);
          test_errs++;
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_err  = exp_err_q.pop_front();
          if (rsp_rdata_i !== exp_data || rsp_err_i !== exp_err) begin
            $display("Mismatch at %0t: access %0d returned %h err %b, expected %h err %b",
                     $time, rsp_count, rsp_rdata_i, rsp_err_i, exp_data, exp_err);
            test_errs++;
          end
        end
        $display("access %0d: %s", rsp_count, (test_errs == 0) ? "pass" : "fail");
        err_count += test_errs;
        test_errs = 0;
        rsp_count++;
      end
      prev_valid = rsp_valid_i;

      // ------------------
      // debug gate
      // ------------------
      // counter reaches zero on the HoldCycles-th edge
      dbg_exp = (edge_cnt > HoldCycles) && dbg_req_i && dbg_enable_i;
      if (dbg_gated_i !== dbg_exp) begin
        $display("Mismatch at %0t: dbg_req_o is %b at edge %0d, expected %b",
                 $time, dbg_gated_i, edge_cnt, dbg_exp);
        dbg_errs++;
      end
      if (edge_cnt == HoldCycles + 1) begin
        $display("debug hold window: %s", (dbg_errs == 0) ? "pass" : "fail");
        err_count += dbg_errs;
        dbg_errs = 0;
        dbg_tests_done++;
      end
      if (!dbg_enable_i && !dbg_dis_seen && edge_cnt > HoldCycles + 1) begin
        $display("debug disable: %s", (dbg_errs == 0) ? "pass" : "fail");
        err_count += dbg_errs;
        dbg_errs = 0;
        dbg_dis_seen = 1'b1;
        dbg_tests_done++;
      end
    end
  end

endmodule

// File: tests/harness_vectors.txt
# op addr be wdata exp_rdata exp_err, every field in hex
# op 0 is a read and op 1 a write, write data is ignored on reads
0 00000000 0 00000000 F1402573 0
0 00000004 0 00000000 800002B7 0
0 00000008 0 00000000 00000593 0
0 0000000C 0 00000000 00028067 0
0 00000010 0 00000000 00000013 0
0 00000014 0 00000000 00000013 0
0 00000018 0 00000000 10500073 0
0 0000001C 0 00000000 FFDFF06F 0
1 80000000 F 11223344 00000000 0
1 80000000 3 AABBCCDD 00000000 0
1 80000000 8 EE000000 00000000 0
0 80000000 0 00000000 EE22CCDD 0
1 80000010 F CAFEF00D 00000000 0
1 80000010 8 55667788 00000000 0
0 80000010 0 00000000 55FEF00D 0
0 80000004 0 00000000 00000000 0
0 800000FC 0 00000000 00000000 0
0 40000000 0 00000000 BADCAB1E 1
1 40000020 F 12345678 BADCAB1E 1
1 00000004 F DEADBEEF BADCAB1E 1
0 00000020 0 00000000 BADCAB1E 1
1 80000100 F DEADBEEF BADCAB1E 1
0 80000100 0 00000000 BADCAB1E 1
0 00000004 0 00000000 800002B7 0
0 80000000 0 00000000 EE22CCDD 0

// File: tests/tb_harness.sv
// Harness testbench

`timescale 1ns/1ps

module tb_harness;

  import harness_pkg::*;

  localparam int unsigned SramWords  = 64;
  localparam int unsigned HoldCycles = 16;
  localparam int          MaxVectors = 64;
  // rom reads lead the file and run with the response channel always ready
  localparam int          UnstalledVectors = 8;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_we_i;
  bus_addr_u req_addr_i;
  strb_t     req_be_i;
  data_t     req_wdata_i;
  logic      req_ready_o;
  logic      rsp_ready_i;
  logic      rsp_valid_o;
  data_t     rsp_rdata_o;
  logic      rsp_err_o;
  logic      dbg_req_i;
  logic      dbg_enable_i;
  logic      dbg_req_o;

  // one entry per vector line
  logic        vec_we    [MaxVectors];
  logic [31:0] vec_addr  [MaxVectors];
  strb_t       vec_be    [MaxVectors];
  data_t       vec_wdata [MaxVectors];
  data_t       vec_rdata [MaxVectors];
  logic        vec_err   [MaxVectors];

  int     n_vec    = 0;
  int     cycles   = 0;
  int     limit    = 0;
  integer seed     = 32'h3b0a;

  harness_top #(
    .SramWords  ( SramWords  ),
    .HoldCycles ( HoldCycles )
  ) u_dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_be_i     ( req_be_i     ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_ready_o  ( req_ready_o  ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_rdata_o  ( rsp_rdata_o  ),
    .rsp_err_o    ( rsp_err_o    ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .dbg_req_o    ( dbg_req_o    )
  );

  harness_checker #(
    .HoldCycles ( HoldCycles )
  ) u_chk (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_i  ( req_ready_o  ),
    .rsp_valid_i  ( rsp_valid_o  ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .rsp_rdata_i  ( rsp_rdata_o  ),
    .rsp_err_i    ( rsp_err_o    ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .dbg_gated_i  ( dbg_req_o    )
  );

  always #5 clk_i = ~clk_i;

  // random back-pressure on the response channel once the rom reads are done
  always @(negedge clk_i) begin
    if (u_chk.rsp_count >= UnstalledVectors) begin
      rsp_ready_i = (($random(seed) & 32'd1) != 0);
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  // ------------------
  // watchdog
  // ------------------
  always @(posedge clk_i) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: responses did not complete");
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic read_vectors();
    int          fd;
    int          code;
    string       line;
    logic [31:0] f_op, f_addr, f_be, f_wd, f_rd, f_err;
    fd = $fopen("tests/harness_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tests/harness_vectors.txt");
      return;
    end
    while (!$feof(fd) && n_vec < MaxVectors) begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_be, f_wd, f_rd, f_err) == 6) begin
          vec_we[n_vec]    = f_op[0];
          vec_addr[n_vec]  = f_addr;
          vec_be[n_vec]    = f_be[StrbWidth-1:0];
          vec_wdata[n_vec] = f_wd;
          vec_rdata[n_vec] = f_rd;
          vec_err[n_vec]   = f_err[0];
          n_vec++;
        end
      end
    end
    $fclose(fd);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_access(input int i);
    req_valid_i     = 1'b1;
    req_we_i        = vec_we[i];
    req_addr_i.flat = vec_addr[i];
    req_be_i        = vec_be[i];
    req_wdata_i     = vec_wdata[i];
    // ready only moves on the rising edge
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // ------------------
  // main sequence
  // ------------------
  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_be_i     = '0;
    req_wdata_i  = '0;
    rsp_ready_i  = 1'b1;
    dbg_req_i    = 1'b1;
    dbg_enable_i = 1'b1;

    read_vectors();
    limit = 20 * n_vec + HoldCycles + 100;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < n_vec; i++) begin
      u_chk.push_expect(vec_rdata[i], vec_err[i]);
      send_access(i);
    end
    while (u_chk.rsp_count < n_vec) @(negedge clk_i);

    // gate has to be open before disable can close it
    while (u_chk.edge_cnt <= HoldCycles + 1) @(negedge clk_i);
    dbg_enable_i = 1'b0;
    repeat (3) @(negedge clk_i);

    u_chk.print_summary();
    if (n_vec > 0 && u_chk.err_count == 0 && u_chk.dbg_tests_done == 2) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
